// File: verilog/fpu_div_sqrt_pkg.sv
package fpu_div_sqrt_pkg;

   ////////////////////////////////////////////////////////////
   // Widths of the binary32 format
   ////////////////////////////////////////////////////////////

   parameter int c_op   = 32;   // Whole operand word
   parameter int c_exp  = 8;    // Biased exponent
   parameter int c_mant = 23;   // Stored fraction, hidden bit excluded
   parameter int c_bias = 127;

   // Rounding modes
   parameter int c_rm = 2;
   parameter logic [c_rm-1:0] rm_nearest  = 2'd0;   // Ties to even
   parameter logic [c_rm-1:0] rm_trunc    = 2'd1;   // Toward zero
   parameter logic [c_rm-1:0] rm_plusinf  = 2'd2;
   parameter logic [c_rm-1:0] rm_minusinf = 2'd3;

   // 24 result bits, one spare for a leading zero quotient, one guard bit
   parameter int c_iter = 26;

   ////////////////////////////////////////////////////////////
   // Operand and result records
   ////////////////////////////////////////////////////////////

   // At most one of these is set
   typedef struct packed {
      logic zero;   // Also covers flushed denormals
      logic inf;
      logic nan;
   } fp_class_t;

   typedef struct packed {
      logic              sign;
      logic [c_exp-1:0]  exp;
      logic [c_mant:0]   frac;   // Hidden bit on top
      fp_class_t         cls;
   } fp_unpacked_t;

   // Recurrence result before normalization
   typedef struct packed {
      logic                      sign;
      logic signed [c_exp+1:0]   exp;      // Biased, weight of mant msb
      logic [c_iter-1:0]         mant;     // Lsb is the guard bit
      logic                      sticky;   // Nonzero final remainder
      logic                      op_sqrt;
      fp_unpacked_t              unp_a;
      fp_unpacked_t              unp_b;
      logic [c_op-1:0]           raw_a;    // For NaN pass-through
      logic [c_op-1:0]           raw_b;
   } prenorm_t;

   typedef struct packed {
      logic overflow;
      logic underflow;
      logic div_zero;
      logic invalid;   // Sqrt of a negative number
   } fp_flags_t;

endpackage

// File: verilog/fpu_operand_class.sv
`timescale 1ns/1ps

module fpu_operand_class (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 start,
   input  logic                                 op_sqrt,
   input  logic [fpu_div_sqrt_pkg::c_rm-1:0]    rm,
   input  logic [fpu_div_sqrt_pkg::c_op-1:0]    operand_a,
   input  logic [fpu_div_sqrt_pkg::c_op-1:0]    operand_b,
   input  logic                                 busy,
   output logic                                 class_valid,
   output fpu_div_sqrt_pkg::fp_unpacked_t       unp_a,
   output fpu_div_sqrt_pkg::fp_unpacked_t       unp_b,
   output logic                                 op_sqrt_q,
   output logic [fpu_div_sqrt_pkg::c_rm-1:0]    rm_q,
   output logic [fpu_div_sqrt_pkg::c_op-1:0]    raw_a,
   output logic [fpu_div_sqrt_pkg::c_op-1:0]    raw_b
);

   logic accept;   // Start seen while idle

   assign accept = start && !busy;

   // Split a word into fields, flush denormals to signed zero
   function automatic fpu_div_sqrt_pkg::fp_unpacked_t unpack(
      input logic [fpu_div_sqrt_pkg::c_op-1:0] w
   );
      fpu_div_sqrt_pkg::fp_unpacked_t u;
      logic exp_zero;
      logic exp_ones;
      logic frac_zero;
      exp_zero  = (w[fpu_div_sqrt_pkg::c_op-2 -: fpu_div_sqrt_pkg::c_exp] == '0);
      exp_ones  = (w[fpu_div_sqrt_pkg::c_op-2 -: fpu_div_sqrt_pkg::c_exp] == '1);
      frac_zero = (w[fpu_div_sqrt_pkg::c_mant-1:0] == '0);
      u.sign     = w[fpu_div_sqrt_pkg::c_op-1];
      u.exp      = w[fpu_div_sqrt_pkg::c_op-2 -: fpu_div_sqrt_pkg::c_exp];
      u.frac     = exp_zero ? '0 : {1'b1, w[fpu_div_sqrt_pkg::c_mant-1:0]};   // Hidden bit
      u.cls.zero = exp_zero;               // Zero or denormal
      u.cls.inf  = exp_ones && frac_zero;
      u.cls.nan  = exp_ones && !frac_zero;
      return u;
   endfunction

   // Start strobe, delayed by the capture
   always_ff @(posedge clk)
   begin
      if (rst)
         class_valid <= 1'b0;
      else
         class_valid <= accept;
   end

   // Request capture
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         raw_a     <= operand_a;
         raw_b     <= operand_b;   // Unused by sqrt but harmless
         op_sqrt_q <= op_sqrt;
         rm_q      <= rm;
      end
   end

   assign unp_a = unpack(raw_a);
   assign unp_b = unpack(raw_b);

   a_class_onehot : assert property (@(posedge clk) disable iff (rst)
      class_valid |-> $onehot0(unp_a.cls) && $onehot0(unp_b.cls));

endmodule

// File: verilog/fpu_div_sqrt_iter.sv
`timescale 1ns/1ps

module fpu_div_sqrt_iter #(
   parameter int mant_w = 24
) (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 class_valid,
   input  fpu_div_sqrt_pkg::fp_unpacked_t       unp_a,
   input  fpu_div_sqrt_pkg::fp_unpacked_t       unp_b,
   input  logic                                 op_sqrt,
   input  logic [fpu_div_sqrt_pkg::c_op-1:0]    raw_a,
   input  logic [fpu_div_sqrt_pkg::c_op-1:0]    raw_b,
   output logic                                 busy,
   output logic                                 pre_valid,
   output fpu_div_sqrt_pkg::prenorm_t           pre
);

   localparam int qw   = mant_w + 2;              // Quotient or root bits
   localparam int rw   = mant_w + 5;              // Partial remainder
   localparam int radw = 2 * qw;                  // Radicand, two bits per step
   localparam int ew   = fpu_div_sqrt_pkg::c_exp + 2;
   localparam int cw   = $clog2(qw + 1);

   // Control
   logic            run;   // Recurrence in progress
   logic [cw-1:0]   cnt;   // Steps left

   // Operation state
   logic                              sqrt_q;
   logic                              sign_q;
   logic signed [ew-1:0]              exp_q;
   logic [mant_w-1:0]                 divisor_q;
   logic [radw-1:0]                   rad_q;
   logic [rw-1:0]                     rem_q;
   logic [qw-1:0]                     q_q;
   fpu_div_sqrt_pkg::fp_unpacked_t    unp_a_q;
   fpu_div_sqrt_pkg::fp_unpacked_t    unp_b_q;
   logic [fpu_div_sqrt_pkg::c_op-1:0] raw_a_q;
   logic [fpu_div_sqrt_pkg::c_op-1:0] raw_b_q;

   // One step of the recurrence
   logic [rw-1:0]          rem_sh;     // Remainder with next radicand pair
   logic [rw:0]            diff;       // Trial subtraction, msb is sign
   logic                   take;       // Result bit
   logic [rw-1:0]          rem_nxt;
   logic signed [ew-1:0]   exp_div;
   logic signed [ew-1:0]   exp_sqrt;

   ////////////////////////////////////////////////////////////
   // Exponent at setup
   ////////////////////////////////////////////////////////////

   assign exp_div = $signed({2'b00, unp_a.exp}) - $signed({2'b00, unp_b.exp})
                  + $signed(ew'(fpu_div_sqrt_pkg::c_bias));

   // Halve the unbiased exponent, odd case handled by radicand shift
   assign exp_sqrt = $signed({3'b000, unp_a.exp[fpu_div_sqrt_pkg::c_exp-1:1]})
                   + (unp_a.exp[0] ? $signed(ew'((fpu_div_sqrt_pkg::c_bias + 1) / 2))
                                   : $signed(ew'((fpu_div_sqrt_pkg::c_bias - 1) / 2)));

   ////////////////////////////////////////////////////////////
   // Restoring step, shared register set
   ////////////////////////////////////////////////////////////

   assign rem_sh = {rem_q[rw-3:0], rad_q[radw-1 -: 2]};

   always_comb
   begin
      if (sqrt_q)
         diff = {1'b0, rem_sh} - {{(rw-qw-1){1'b0}}, q_q, 2'b01};   // Trial 4r+1
      else
         diff = {1'b0, rem_q} - {{(rw+1-mant_w){1'b0}}, divisor_q};
   end

   assign take = !diff[rw];   // No borrow

   always_comb
   begin
      if (sqrt_q)
         rem_nxt = take ? diff[rw-1:0] : rem_sh;
      else
         rem_nxt = take ? {diff[rw-2:0], 1'b0} : {rem_q[rw-2:0], 1'b0};
   end

   // Step counter and strobes
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         run       <= 1'b0;
         cnt       <= '0;
         pre_valid <= 1'b0;
      end
      else
      begin
         pre_valid <= run && (cnt == cw'(1));   // Last step
         if (class_valid)
         begin
            run <= 1'b1;
            cnt <= cw'(qw);
         end
         else if (run)
         begin
            cnt <= cnt - 1'b1;
            if (cnt == cw'(1))
               run <= 1'b0;
         end
      end
   end

   // Datapath
   always_ff @(posedge clk)
   begin
      if (class_valid)   // Setup cycle
      begin
         sqrt_q    <= op_sqrt;
         sign_q    <= op_sqrt ? unp_a.sign : unp_a.sign ^ unp_b.sign;
         exp_q     <= op_sqrt ? exp_sqrt : exp_div;
         divisor_q <= unp_b.frac;
         q_q       <= '0;
         rem_q     <= op_sqrt ? '0 : {{(rw-mant_w){1'b0}}, unp_a.frac};
         if (unp_a.exp[0])
            rad_q <= {1'b0, unp_a.frac, {(mant_w+3){1'b0}}};
         else
            rad_q <= {unp_a.frac, {(mant_w+4){1'b0}}};   // Odd unbiased exponent
         unp_a_q   <= unp_a;
         unp_b_q   <= unp_b;
         raw_a_q   <= raw_a;
         raw_b_q   <= raw_b;
      end
      else if (run)
      begin
         q_q   <= {q_q[qw-2:0], take};
         rem_q <= rem_nxt;
         rad_q <= {rad_q[radw-3:0], 2'b00};
      end
   end

   always_comb
   begin
      pre.sign    = sign_q;
      pre.exp     = exp_q;
      pre.mant    = q_q;
      pre.sticky  = |rem_q;   // Inexact beyond the guard bit
      pre.op_sqrt = sqrt_q;
      pre.unp_a   = unp_a_q;
      pre.unp_b   = unp_b_q;
      pre.raw_a   = raw_a_q;
      pre.raw_b   = raw_b_q;
   end

   assign busy = run || pre_valid;

   // One operation at a time
   a_pre_valid_gap : assert property (@(posedge clk) disable iff (rst)
      pre_valid |=> !pre_valid [*fpu_div_sqrt_pkg::c_iter]);

endmodule

// File: verilog/fpu_norm.sv
`timescale 1ns/1ps

module fpu_norm #(
   parameter int mant_w = 24
) (
   input  fpu_div_sqrt_pkg::prenorm_t           pre,
   input  logic [fpu_div_sqrt_pkg::c_rm-1:0]    rm,
   output logic [fpu_div_sqrt_pkg::c_mant-1:0]  mant_res,
   output logic [fpu_div_sqrt_pkg::c_exp-1:0]   exp_res,
   output logic                                 sign_res,
   output fpu_div_sqrt_pkg::fp_flags_t          flags
);

   localparam int qw = mant_w + 2;
   localparam int ew = fpu_div_sqrt_pkg::c_exp + 2;
   localparam int ce = fpu_div_sqrt_pkg::c_exp;
   localparam int cm = fpu_div_sqrt_pkg::c_mant;
   localparam int co = fpu_div_sqrt_pkg::c_op;

   // Normalization
   logic [qw-1:0]          mant_n;    // Msb set
   logic signed [ew-1:0]   exp_n;
   logic                   den;       // Result below the normal range
   logic                   ovf_pre;   // Too large before rounding
   logic [ew-1:0]          rsh_raw;
   logic [ew-1:0]          rsh;
   logic [2*qw-1:0]        wide;      // Upper half kept, lower half lost
   logic [mant_w-1:0]      sig;
   logic                   guard;
   logic                   sticky;

   // Rounding
   logic                   inexact;
   logic                   round_up;
   logic [mant_w:0]        sum;
   logic [ce-1:0]          exp_rnd;
   logic                   ovf_rnd;

   ////////////////////////////////////////////////////////////
   // Normalize and denormalize
   ////////////////////////////////////////////////////////////

   // Quotient below one needs a single left shift, a root never does
   assign mant_n = pre.mant[qw-1] ? pre.mant : {pre.mant[qw-2:0], 1'b0};
   assign exp_n  = pre.mant[qw-1] ? pre.exp : pre.exp - $signed(ew'(1));

   assign den     = exp_n[ew-1] || (exp_n == '0);
   assign ovf_pre = !exp_n[ew-1] && (exp_n[ew-2:0] >= (ew-1)'(2**ce - 1));

   // Shift by 1 - exp into the denormal position
   assign rsh_raw = ew'(1) - exp_n;

   always_comb
   begin
      if (!den)
         rsh = '0;
      else if (rsh_raw > ew'(qw))
         rsh = ew'(qw);   // Everything lands in the sticky
      else
         rsh = rsh_raw;
   end

   assign wide   = {mant_n, {qw{1'b0}}} >> rsh;
   assign sig    = wide[2*qw-1 -: mant_w];
   assign guard  = wide[qw+1];
   assign sticky = pre.sticky || (|wide[qw:0]);

   ////////////////////////////////////////////////////////////
   // Round
   ////////////////////////////////////////////////////////////

   assign inexact = guard || sticky;

   always_comb
   begin
      case (rm)
         fpu_div_sqrt_pkg::rm_nearest  : round_up = guard && (sticky || sig[0]);
         fpu_div_sqrt_pkg::rm_trunc    : round_up = 1'b0;
         fpu_div_sqrt_pkg::rm_plusinf  : round_up = inexact && !pre.sign;
         fpu_div_sqrt_pkg::rm_minusinf : round_up = inexact && pre.sign;
         default                       : round_up = 1'b0;
      endcase
   end

   assign sum = {1'b0, sig} + (mant_w+1)'(round_up);

   // Carry out leaves a zero fraction, only the exponent moves
   always_comb
   begin
      if (den)
         exp_rnd = ce'(sum[mant_w-1]);   // Denormal rounding up to the smallest normal
      else
         exp_rnd = exp_n[ce-1:0] + ce'(sum[mant_w]);
   end

   assign ovf_rnd = ovf_pre || (exp_rnd == '1);

   ////////////////////////////////////////////////////////////
   // Special values, then the computed result
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      flags    = '0;
      sign_res = pre.sign;
      exp_res  = '0;
      mant_res = '0;
      if (pre.unp_a.cls.nan)   // Pass a through with payload
      begin
         sign_res = pre.raw_a[co-1];
         exp_res  = pre.raw_a[co-2 -: ce];
         mant_res = pre.raw_a[cm-1:0];
      end
      else if (!pre.op_sqrt && pre.unp_b.cls.nan)
      begin
         sign_res = pre.raw_b[co-1];
         exp_res  = pre.raw_b[co-2 -: ce];
         mant_res = pre.raw_b[cm-1:0];
      end
      else if (pre.op_sqrt && pre.unp_a.sign && !pre.unp_a.cls.zero)
      begin
         sign_res      = 1'b0;   // Canonical quiet NaN
         exp_res       = '1;
         mant_res      = {1'b1, {(cm-1){1'b0}}};
         flags.invalid = 1'b1;
      end
      else if (pre.unp_a.cls.inf)
         exp_res = '1;
      else if (!pre.op_sqrt && pre.unp_b.cls.inf)
         exp_res = '0;   // x / inf
      else if (!pre.op_sqrt && pre.unp_b.cls.zero)
      begin
         exp_res        = '1;
         flags.div_zero = 1'b1;
      end
      else if (pre.unp_a.cls.zero)
         exp_res = '0;   // Signed zero, also sqrt(-0)
      else if (ovf_rnd)
      begin
         exp_res        = '1;
         flags.overflow = 1'b1;
      end
      else
      begin
         exp_res         = exp_rnd;
         mant_res        = sum[cm-1:0];
         flags.underflow = den && inexact;
      end
   end

endmodule

// File: verilog/fpu_div_sqrt_top.sv
`timescale 1ns/1ps

module fpu_div_sqrt_top #(
   parameter int mant_w = 24
) (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 start,
   input  logic                                 op_sqrt,
   input  logic [fpu_div_sqrt_pkg::c_rm-1:0]    rm,
   input  logic [fpu_div_sqrt_pkg::c_op-1:0]    operand_a,
   input  logic [fpu_div_sqrt_pkg::c_op-1:0]    operand_b,
   output logic                                 busy,
   output logic                                 done,
   output logic [fpu_div_sqrt_pkg::c_op-1:0]    result,
   output fpu_div_sqrt_pkg::fp_flags_t          flags
);

   // Classification stage
   logic                                  class_valid;
   fpu_div_sqrt_pkg::fp_unpacked_t        unp_a;
   fpu_div_sqrt_pkg::fp_unpacked_t        unp_b;
   logic                                  op_sqrt_q;
   logic [fpu_div_sqrt_pkg::c_rm-1:0]     rm_q;   // Held until done
   logic [fpu_div_sqrt_pkg::c_op-1:0]     raw_a;
   logic [fpu_div_sqrt_pkg::c_op-1:0]     raw_b;

   // Recurrence and normalizer
   logic                                  iter_busy;
   logic                                  pre_valid;
   fpu_div_sqrt_pkg::prenorm_t            pre;
   logic [fpu_div_sqrt_pkg::c_mant-1:0]   mant_res;
   logic [fpu_div_sqrt_pkg::c_exp-1:0]    exp_res;
   logic                                  sign_res;
   fpu_div_sqrt_pkg::fp_flags_t           norm_flags;

   assign busy = class_valid || iter_busy || done;   // Cycle after start through done

   fpu_operand_class u_class (
      .clk         (clk),
      .rst         (rst),
      .start       (start),
      .op_sqrt     (op_sqrt),
      .rm          (rm),
      .operand_a   (operand_a),
      .operand_b   (operand_b),
      .busy        (busy),
      .class_valid (class_valid),
      .unp_a       (unp_a),
      .unp_b       (unp_b),
      .op_sqrt_q   (op_sqrt_q),
      .rm_q        (rm_q),
      .raw_a       (raw_a),
      .raw_b       (raw_b)
   );

   fpu_div_sqrt_iter #(.mant_w(mant_w)) u_iter (
      .clk         (clk),
      .rst         (rst),
      .class_valid (class_valid),
      .unp_a       (unp_a),
      .unp_b       (unp_b),
      .op_sqrt     (op_sqrt_q),
      .raw_a       (raw_a),
      .raw_b       (raw_b),
      .busy        (iter_busy),
      .pre_valid   (pre_valid),
      .pre         (pre)
   );

   fpu_norm #(.mant_w(mant_w)) u_norm (
      .pre      (pre),
      .rm       (rm_q),
      .mant_res (mant_res),
      .exp_res  (exp_res),
      .sign_res (sign_res),
      .flags    (norm_flags)
   );

   // Output register, one cycle after the last step
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         done   <= 1'b0;
         result <= '0;
         flags  <= '0;
      end
      else
      begin
         done <= pre_valid;
         if (pre_valid)
         begin
            result <= {sign_res, exp_res, mant_res};
            flags  <= norm_flags;
         end
      end
   end

   a_no_done_on_accept : assert property (@(posedge clk) disable iff (rst)
      (start && !busy) |-> !done);

endmodule

// File: verif/fpu_div_sqrt_checks.svh
////////////////////////////////////////////////////////////
// Response checks at done
////////////////////////////////////////////////////////////

a_result : assert property (@(posedge clk) disable iff (rst)
   done |-> result == exp_result)
   else report_failure($sformatf("Fail result: got %h, expected %h",
                                 $sampled(result), $sampled(exp_result)));

a_flags : assert property (@(posedge clk) disable iff (rst)
   done |-> flags == exp_flags)
   else report_failure($sformatf("Fail flags: got %h, expected %h",
                                 $sampled(flags), $sampled(exp_flags)));

////////////////////////////////////////////////////////////
// Handshake and latency
////////////////////////////////////////////////////////////

// Accepted start to done, fixed for every operand class
a_latency : assert property (@(posedge clk) disable iff (rst)
   (start && !busy) |-> ##29 done)
   else report_failure("done did not arrive 29 cycles after an accepted start");

a_busy_span : assert property (@(posedge clk) disable iff (rst)
   (start && !busy) |=> busy [*29])
   else report_failure("busy dropped between an accepted start and its done");

// Also catches a done caused by a start seen while busy
a_done_source : assert property (@(posedge clk) disable iff (rst)
   done |-> $past(start && !busy, 29))
   else report_failure("done without an accepted start 29 cycles earlier");

a_idle_after_done : assert property (@(posedge clk) disable iff (rst)
   done |=> !busy)
   else report_failure("busy still high in the cycle after done");

// Output register only moves with done
a_hold : assert property (@(posedge clk) disable iff (rst)
   !done |-> $stable(result) && $stable(flags))
   else report_failure("result or flags changed without a done strobe");

////////////////////////////////////////////////////////////
// Reset state
////////////////////////////////////////////////////////////

a_reset_state : assert property (@(posedge clk)
   rst |=> !done && !busy && result == '0 && flags == '0)
   else report_failure($sformatf("Fail after reset: done %h busy %h result %h flags %h",
                                 $sampled(done), $sampled(busy),
                                 $sampled(result), $sampled(flags)));

// File: verif/fpu_div_sqrt_tb.sv
`timescale 1ns/1ps

module fpu_div_sqrt_tb;

   logic                                clk;
   logic                                rst;
   logic                                start;
   logic                                op_sqrt;
   logic [fpu_div_sqrt_pkg::c_rm-1:0]   rm;
   logic [fpu_div_sqrt_pkg::c_op-1:0]   operand_a;
   logic [fpu_div_sqrt_pkg::c_op-1:0]   operand_b;
   logic                                busy;
   logic                                done;
   logic [fpu_div_sqrt_pkg::c_op-1:0]   result;
   fpu_div_sqrt_pkg::fp_flags_t         flags;

   // Expected response of the operation in flight
   logic [fpu_div_sqrt_pkg::c_op-1:0]   exp_result;
   fpu_div_sqrt_pkg::fp_flags_t         exp_flags;

   fpu_div_sqrt_top #(.mant_w(24)) dut_i (
      .clk       (clk),
      .rst       (rst),
      .start     (start),
      .op_sqrt   (op_sqrt),
      .rm        (rm),
      .operand_a (operand_a),
      .operand_b (operand_b),
      .busy      (busy),
      .done      (done),
      .result    (result),
      .flags     (flags)
   );

   always
   begin
      #4 clk = ~clk;   // 8 ns period
   end

   ////////////////////////////////////////////////////////////
   // Reference model in double precision
   ////////////////////////////////////////////////////////////

   // Normal binary32 word widened to a double, rebias 127 to 1023
   function automatic real to_real(input logic [31:0] w);
      logic [63:0] d;
      d = {w[31], 11'(w[30:23]) + 11'd896, w[22:0], 29'b0};
      return $bitstoreal(d);
   endfunction

   // Round a double with a normal binary32 range down to 24 bits
   function automatic logic [31:0] round_single(input real q,
                                                input logic [fpu_div_sqrt_pkg::c_rm-1:0] mode);
      logic [63:0] d;
      logic [31:0] t;      // Truncated magnitude
      logic [31:0] away;   // One ulp further from zero
      logic [31:0] r;
      logic        half;
      logic        below;
      d     = $realtobits(q);
      t     = {d[63], 8'(d[62:52] - 11'd896), d[51:29]};
      away  = {t[31], t[30:0] + 31'd1};   // Carry moves into the exponent
      half  = d[28];
      below = |d[27:0];
      case (mode)
         fpu_div_sqrt_pkg::rm_nearest : r = (half && (below || t[0])) ? away : t;
         fpu_div_sqrt_pkg::rm_trunc   : r = t;
         fpu_div_sqrt_pkg::rm_plusinf : r = ((half || below) && !t[31]) ? away : t;
         default                      : r = ((half || below) && t[31]) ? away : t;
      endcase
      return r;
   endfunction

   function automatic logic [31:0] rand_normal(input int emin, input int emax, input logic neg);
      logic       s;
      logic [7:0] e;
      s = neg & 1'($urandom);
      e = 8'($urandom_range(emax, emin));
      return {s, e, 23'($urandom)};
   endfunction

   function automatic fpu_div_sqrt_pkg::fp_flags_t make_flags(input logic ov, input logic uf,
                                                             input logic dz, input logic inv);
      fpu_div_sqrt_pkg::fp_flags_t f;
      f.overflow  = ov;
      f.underflow = uf;
      f.div_zero  = dz;
      f.invalid   = inv;
      return f;
   endfunction

   ////////////////////////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////////////////////////

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at the first error");
   endtask

   // One cycle start strobe, expected response recorded with it
   task automatic start_op(input logic sq, input logic [fpu_div_sqrt_pkg::c_rm-1:0] mode,
                           input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] want, input fpu_div_sqrt_pkg::fp_flags_t want_f);
      @(posedge clk);
      start      <= 1'b1;
      op_sqrt    <= sq;
      rm         <= mode;
      operand_a  <= a;
      operand_b  <= b;
      exp_result <= want;
      exp_flags  <= want_f;
      @(posedge clk);
      start <= 1'b0;
   endtask

   // Second start a few cycles into a running operation, must be ignored
   task automatic start_while_busy(input logic [31:0] a, input logic [31:0] b);
      repeat (4) @(posedge clk);
      start     <= 1'b1;
      operand_a <= a;
      operand_b <= b;
      @(posedge clk);
      start <= 1'b0;
   endtask

   task automatic wait_done;
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!done && cycles < 40)
      begin
         cycles++;
         @(negedge clk);
      end
      if (!done)
         report_failure("No done within 40 cycles of the start strobe");
      else
         @(negedge clk);   // Let the done cycle pass
   endtask

   task automatic run_op(input logic sq, input logic [fpu_div_sqrt_pkg::c_rm-1:0] mode,
                         input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] want, input fpu_div_sqrt_pkg::fp_flags_t want_f);
      start_op(sq, mode, a, b, want, want_f);
      wait_done();
   endtask

   task automatic check_div(input logic [fpu_div_sqrt_pkg::c_rm-1:0] mode,
                            input logic [31:0] a, input logic [31:0] b);
      run_op(1'b0, mode, a, b, round_single(to_real(a) / to_real(b), mode), '0);
   endtask

   task automatic check_sqrt(input logic [fpu_div_sqrt_pkg::c_rm-1:0] mode,
                             input logic [31:0] a);
      run_op(1'b1, mode, a, 32'h0, round_single($sqrt(to_real(a)), mode), '0);
   endtask

   ////////////////////////////////////////////////////////////
   // Sequences
   ////////////////////////////////////////////////////////////

   initial
   begin
      void'($urandom(83119));
      clk        = 1'b0;
      rst        = 1'b1;
      start      = 1'b0;
      op_sqrt    = 1'b0;
      rm         = fpu_div_sqrt_pkg::rm_nearest;
      operand_a  = '0;
      operand_b  = '0;
      exp_result = '0;
      exp_flags  = '0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      // Handshake, 6 / 3 with a stray start in the middle
      start_op(1'b0, fpu_div_sqrt_pkg::rm_nearest, 32'h40C00000, 32'h40400000,
               32'h40000000, '0);
      start_while_busy(32'h3F800000, 32'h40E00000);
      wait_done();

      for (int i = 0; i < 40; i++)
      begin
         check_div(fpu_div_sqrt_pkg::rm_nearest, rand_normal(100, 154, 1'b1),
                   rand_normal(100, 154, 1'b1));
         check_sqrt(fpu_div_sqrt_pkg::rm_nearest, rand_normal(1, 254, 1'b0));
      end

      // All four modes, exact pairs first
      for (int m = 0; m < 4; m++)
      begin
         check_div(2'(m), 32'h40C00000, 32'h40400000);   // 6 / 3
         check_sqrt(2'(m), 32'h40100000);                // sqrt 2.25
         check_div(2'(m), 32'h3F800000, 32'h40400000);   // 1 / 3
         check_div(2'(m), 32'hC0000000, 32'h40400000);   // -2 / 3
         check_div(2'(m), 32'h41200000, 32'hC0E00000);   // 10 / -7
         check_sqrt(2'(m), 32'h40000000);
         for (int i = 0; i < 6; i++)
         begin
            check_div(2'(m), rand_normal(100, 154, 1'b1), rand_normal(100, 154, 1'b1));
            check_sqrt(2'(m), rand_normal(1, 254, 1'b0));
         end
      end

      // Special operands, payloads kept
      run_op(1'b0, 2'd0, 32'h7FC12345, 32'h3F800000, 32'h7FC12345, '0);
      run_op(1'b0, 2'd0, 32'h3F800000, 32'hFF812345, 32'hFF812345, '0);
      run_op(1'b1, 2'd0, 32'h7FA00001, 32'h0, 32'h7FA00001, '0);
      run_op(1'b0, 2'd0, 32'h3F800000, 32'h00000000, 32'h7F800000, make_flags(0, 0, 1, 0));
      run_op(1'b0, 2'd0, 32'hC0000000, 32'h00000000, 32'hFF800000, make_flags(0, 0, 1, 0));
      run_op(1'b0, 2'd0, 32'h3F800000, 32'h00000001, 32'h7F800000, make_flags(0, 0, 1, 0));
      run_op(1'b0, 2'd0, 32'hFF800000, 32'h40000000, 32'hFF800000, '0);
      run_op(1'b0, 2'd0, 32'h40400000, 32'hFF800000, 32'h80000000, '0);
      run_op(1'b1, 2'd0, 32'hC0800000, 32'h0, 32'h7FC00000, make_flags(0, 0, 0, 1));
      run_op(1'b1, 2'd0, 32'h80000000, 32'h0, 32'h80000000, '0);   // Signed zero kept
      run_op(1'b1, 2'd0, 32'h7F800000, 32'h0, 32'h7F800000, '0);

      // 2^100 / 2^-100 overflows, 2^-100 / 2^40 is the exact denormal 2^-140
      run_op(1'b0, 2'd0, 32'h71800000, 32'h0D800000, 32'h7F800000, make_flags(1, 0, 0, 0));
      run_op(1'b0, 2'd0, 32'h0D800000, 32'h53800000, 32'h00000200, '0);
      // 2^-126 / 3 is 2^23/3 units of 2^-149, rounds up to 0x2AAAAB
      run_op(1'b0, 2'd0, 32'h00800000, 32'h40400000, 32'h002AAAAB, make_flags(0, 1, 0, 0));

      repeat (2) @(posedge clk);
      $display("NO ERRORS");
      $finish;
   end

   `include "fpu_div_sqrt_checks.svh"

endmodule

// File: fpu_div_sqrt.f
+incdir+verif
verilog/fpu_div_sqrt_pkg.sv
verilog/fpu_operand_class.sv
verilog/fpu_div_sqrt_iter.sv
verilog/fpu_norm.sv
verilog/fpu_div_sqrt_top.sv
verif/fpu_div_sqrt_tb.sv

// File: Makefile
# Verilator build of the divide and square-root testbench

VERILATOR ?= verilator
TOP       := fpu_div_sqrt_tb
FILELIST  := fpu_div_sqrt.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a nonzero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
